/* source/gift_params.svh */
/*
 * Sizes shared by the GIFT-128 decryptor. The round count must match the
 * 40-entry constant table, so it is not a free choice.
 */
`ifndef GIFT_PARAMS_SVH
`define GIFT_PARAMS_SVH

`define GIFT_STATE_WIDTH 128 // Block and key state
`define GIFT_ROUND_COUNT 40  // Also the pipeline depth
`define GIFT_CONST_WIDTH 6
`define GIFT_NIBBLE_COUNT 32 // S-box lanes per round

`endif

/* source/giftStatePkg.sv */
/*
 * Data and key state views for GIFT-128. The key union gives the 16-bit
 * words used by the key schedule and the 32-bit words that hold U and V.
 */
`include "gift_params.svh"

package giftStatePkg;

    typedef logic [`GIFT_STATE_WIDTH-1:0] giftStateT;

    // words16[7] is k7, the top word of the key state
    // halves32[2] is U = k5||k4, halves32[0] is V = k1||k0
    typedef union packed {
        logic [`GIFT_STATE_WIDTH/16-1:0][15:0] words16;
        logic [`GIFT_STATE_WIDTH/32-1:0][31:0] halves32;
    } giftKeyT;

    // Element s is the key state held at stage s
    typedef giftKeyT [`GIFT_ROUND_COUNT-1:0] giftKeyArrayT;

endpackage

/* source/giftConstPkg.sv */
/*
 * GIFT-128 tables for the decrypt direction. Entry r of the constant table
 * belongs to encryption round r+1. Only the inverse S-box and the inverse
 * bit permutation are kept here.
 */
`include "gift_params.svh"

package giftConstPkg;

    // 6-bit LFSR round constants starting at round 1
    localparam logic [`GIFT_CONST_WIDTH-1:0] giftRoundConst [`GIFT_ROUND_COUNT] = '{
        6'h01, 6'h03, 6'h07, 6'h0f, 6'h1f, 6'h3e, 6'h3d, 6'h3b,
        6'h37, 6'h2f, 6'h1e, 6'h3c, 6'h39, 6'h33, 6'h27, 6'h0e,
        6'h1d, 6'h3a, 6'h35, 6'h2b, 6'h16, 6'h2c, 6'h18, 6'h30,
        6'h21, 6'h02, 6'h05, 6'h0b, 6'h17, 6'h2e, 6'h1c, 6'h38,
        6'h31, 6'h23, 6'h06, 6'h0d, 6'h1b, 6'h36, 6'h2d, 6'h1a
    };

    // Inverse of S = 1a4c6f392db7508e
    localparam logic [3:0] giftInvSbox [16] = '{
        4'hd, 4'h0, 4'h8, 4'h6, 4'h2, 4'hc, 4'h4, 4'hb,
        4'he, 4'h7, 4'h1, 4'ha, 4'h3, 4'h9, 4'hf, 4'h5
    };

    // Forward permutation sends bit i to P(i), so the inverse gathers it back
    function automatic logic [`GIFT_STATE_WIDTH-1:0] giftInvPerm(
        input logic [`GIFT_STATE_WIDTH-1:0] inState
    );
        logic [`GIFT_STATE_WIDTH-1:0] outState;
        int dest;
        for (int i = 0; i < `GIFT_STATE_WIDTH; i++) begin
            dest = 4 * (i / 16)
                 + 32 * ((3 * ((i % 16) / 4) + (i % 4)) % 4)
                 + (i % 4);
            outState[i] = inState[dest];
        end
        return outState;
    endfunction

endpackage

/* source/giftInvRound.sv */
/*
 * One GIFT-128 round undone, purely combinational. Key and constant are
 * removed first, then the permutation, then the S-box layer.
 */
`include "gift_params.svh"

module giftInvRound
    import giftStatePkg::*;
    import giftConstPkg::*;
(
    input  giftStateT                    state,
    input  giftKeyT                      roundKey,
    input  logic [`GIFT_CONST_WIDTH-1:0] roundConst,
    output giftStateT                    result
);

    giftStateT keyed;
    giftStateT unPerm;

    always_comb begin
        keyed = state;
        for (int i = 0; i < `GIFT_NIBBLE_COUNT; i++) begin
            keyed[4*i+2] = state[4*i+2] ^ roundKey.halves32[2][i]; // U
            keyed[4*i+1] = state[4*i+1] ^ roundKey.halves32[0][i]; // V
        end
        for (int j = 0; j < `GIFT_CONST_WIDTH; j++) begin
            keyed[4*j+3] = keyed[4*j+3] ^ roundConst[j]; // Bits 3..23
        end
        keyed[`GIFT_STATE_WIDTH-1] = ~keyed[`GIFT_STATE_WIDTH-1];
    end

    assign unPerm = giftInvPerm(keyed);

    always_comb begin
        for (int n = 0; n < `GIFT_NIBBLE_COUNT; n++) begin
            result[4*n +: 4] = giftInvSbox[unPerm[4*n +: 4]];
        end
    end

endmodule

/* source/giftKeyPipe.sv */
/*
 * Key state staggered alongside the data pipe. Stage 0 holds the key of
 * the last encryption round; each later stage holds the key one round
 * earlier. Contents count only where the matching valid bit is set.
 */
`include "gift_params.svh"

module giftKeyPipe
    import giftStatePkg::*;
(
    input  logic         inClk,
    input  giftKeyT      inKey,
    output giftKeyArrayT stageKeys
);

    giftKeyArrayT keyReg;
    giftKeyT      earlierKey [`GIFT_ROUND_COUNT-1];

    // Each stage undoes the forward update k1>>>2 || k0>>>12 || k7..k2
    genvar s;
    generate
        for (s = 0; s < `GIFT_ROUND_COUNT - 1; s++) begin : genKeyStep
            assign earlierKey[s] = {
                keyReg[s].words16[5:0],                                  // k7..k2
                keyReg[s].words16[7][13:0], keyReg[s].words16[7][15:14], // k1
                keyReg[s].words16[6][3:0], keyReg[s].words16[6][15:4]    // k0
            };
        end
    endgenerate

    always_ff @(posedge inClk) begin
        keyReg[0] <= inKey;
        for (int i = 1; i < `GIFT_ROUND_COUNT; i++) begin
            keyReg[i] <= earlierKey[i-1];
        end
    end

    assign stageKeys = keyReg;

endmodule

/* source/giftDataPipe.sv */
/*
 * Data and valid chain of the decryptor, one inverse round per stage.
 * Latency is 40 edges with no stall; outputs come straight from the last
 * round's logic. Reset clears the valid chain only.
 */
`include "gift_params.svh"

module giftDataPipe
    import giftStatePkg::*;
    import giftConstPkg::*;
(
    input  logic         inClk,
    input  logic         reset,
    input  logic         inValid,
    input  giftStateT    inData,
    input  giftKeyArrayT stageKeys,
    output logic         outValid,
    output giftStateT    outData
);

    giftStateT                   dataReg  [`GIFT_ROUND_COUNT];
    giftStateT                   roundOut [`GIFT_ROUND_COUNT];
    logic [`GIFT_ROUND_COUNT-1:0] validReg;

    // Stage s undoes encryption round ROUND_COUNT-s
    genvar s;
    generate
        for (s = 0; s < `GIFT_ROUND_COUNT; s++) begin : genStage
            giftInvRound i_invRound (
                .state      (dataReg[s]),
                .roundKey   (stageKeys[s]),
                .roundConst (giftRoundConst[`GIFT_ROUND_COUNT-1-s]),
                .result     (roundOut[s])
            );
        end
    endgenerate

    always_ff @(posedge inClk) begin
        dataReg[0] <= inData;
        for (int i = 1; i < `GIFT_ROUND_COUNT; i++) begin
            dataReg[i] <= roundOut[i-1];
        end
    end

    always_ff @(posedge inClk) begin
        if (reset) begin
            validReg <= '0;
        end else begin
            validReg <= {validReg[`GIFT_ROUND_COUNT-2:0], inValid}; // Follows dataReg
        end
    end

    assign outData  = roundOut[`GIFT_ROUND_COUNT-1];
    assign outValid = validReg[`GIFT_ROUND_COUNT-1];

endmodule

/* source/giftDecryptTop.sv */
/*
 * Pipelined GIFT-128 decryptor. inKey is the final round-key state, not
 * the user key. One block per clock, 40 edges latency, no back-pressure.
 */
module giftDecryptTop
    import giftStatePkg::*;
(
    input  logic      inClk,
    input  logic      reset,
    input  logic      inValid,
    input  giftStateT inData,
    input  giftKeyT   inKey,
    output logic      outValid,
    output giftStateT outData
);

    giftKeyArrayT stageKeys;

    giftKeyPipe i_keyPipe (
        .inClk     (inClk),
        .inKey     (inKey),
        .stageKeys (stageKeys)
    );

    giftDataPipe i_dataPipe (
        .inClk     (inClk),
        .reset     (reset),
        .inValid   (inValid),
        .inData    (inData),
        .stageKeys (stageKeys), // Aligned with dataReg per stage
        .outValid  (outValid),
        .outData   (outData)
    );

endmodule

/* dv/giftDecryptTb.sv */
/*
 * Testbench for giftDecryptTop. Run from the project root so the vector
 * file path resolves. Expects 40 edges of latency and no back-pressure.
 */
`include "gift_params.svh"

module giftDecryptTb
    import giftStatePkg::*;
();

    localparam int vectorCount = 3;
    localparam int latency     = `GIFT_ROUND_COUNT;
    localparam int drainLimit  = `GIFT_ROUND_COUNT + 16;
    localparam int cycleLimit  = 5000;

    logic      inClk;
    logic      reset;
    logic      inValid;
    giftStateT inData;
    giftKeyT   inKey;
    logic      outValid;
    giftStateT outData;

    giftStateT   vectorMem [0:3*vectorCount-1]; // Key, ciphertext, plaintext
    giftStateT   expQueue [$];
    int          stampQueue [$];
    int          edgeCount = 0;
    int          checkCount = 0;
    int          errorCount = 0;
    int          issuedCount = 0;
    int          receivedCount = 0;
    logic [15:0] lfsrState = 16'd44950;
    string       testName = "idle";

    giftDecryptTop i_giftDecryptTop (
        .inClk    (inClk),
        .reset    (reset),
        .inValid  (inValid),
        .inData   (inData),
        .inKey    (inKey),
        .outValid (outValid),
        .outData  (outData)
    );

    initial inClk = 1'b0;
    always #4 inClk = ~inClk;

    task automatic checkValue(input string name, input giftStateT expected,
                              input giftStateT actual);
        checkCount++;
        if (expected !== actual) begin
            $display("Error %s: expected %h, actual %h", name, expected, actual);
            errorCount++;
        end
    endtask

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsrNext(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    task automatic drawGap(output int gap);
        logic [1:0] bits;
        lfsrState = lfsrNext(lfsrState);
        bits[0] = lfsrState[0];
        lfsrState = lfsrNext(lfsrState);
        bits[1] = lfsrState[0];
        gap = int'(bits);
    endtask

    // DUT samples on the edge after this one
    task automatic issueVector(input int idx);
        @(posedge inClk);
        inValid <= 1'b1;
        inKey   <= giftKeyT'(vectorMem[3*idx]);
        inData  <= vectorMem[3*idx+1];
        expQueue.push_back(vectorMem[3*idx+2]);
        stampQueue.push_back(edgeCount + 1);
        issuedCount++;
    endtask

    task automatic idleCycle();
        @(posedge inClk);
        inValid <= 1'b0;
    endtask

    task automatic waitDrain();
        int waited;
        waited = 0;
        while (expQueue.size() > 0 && waited < drainLimit) begin
            @(negedge inClk);
            waited++;
        end
        if (expQueue.size() > 0) begin
            $display("Timeout in %s: %0d results never came out", testName, expQueue.size());
            errorCount++;
        end
    endtask

    // Caller raises reset first; DUT sees it for 5 edges
    task automatic holdReset();
        for (int c = 0; c < 5; c++) begin
            @(posedge inClk);
            if (c == 4) begin
                reset   <= 1'b0;
                inValid <= 1'b0;
            end
            @(negedge inClk);
            checkValue({testName, " outValid"}, '0, giftStateT'(outValid));
        end
    endtask

    task automatic checkQuiet(input int cycles);
        for (int c = 0; c < cycles; c++) begin
            @(negedge inClk);
            checkValue({testName, " outValid"}, '0, giftStateT'(outValid));
        end
    endtask

    task automatic closeRun();
        $display("Checks: %0d, errors: %0d, issued: %0d, received: %0d",
                 checkCount, errorCount, issuedCount, receivedCount);
        if (errorCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    endtask

    // Scoreboard samples values from before the edge
    always @(posedge inClk) begin : outputMonitor
        giftStateT expected;
        int        stamp;
        edgeCount <= edgeCount + 1;
        if (outValid === 1'b1) begin
            if (expQueue.size() == 0) begin
                $display("Output %h came out with no block in flight", outData);
                errorCount++;
            end else begin
                expected = expQueue.pop_front();
                stamp = stampQueue.pop_front();
                checkValue(testName, expected, outData);
                checkValue({testName, " latency"}, giftStateT'(stamp + latency),
                           giftStateT'(edgeCount));
                receivedCount++;
            end
        end
    end

    initial begin : watchdog
        repeat (cycleLimit) @(posedge inClk);
        $display("Simulation ran past %0d cycles without finishing", cycleLimit);
        errorCount++;
        closeRun();
    end

    initial begin : mainSequence
        int gap;
        int issuedStart;
        int receivedStart;
        $readmemh("dv/gift_testdata.hex", vectorMem);
        reset   <= 1'b1;
        inValid <= 1'b1; // Reset must keep this out of the pipe
        inKey   <= giftKeyT'(vectorMem[3]); // Nonzero while idle
        inData  <= vectorMem[4];

        testName = "resetState";
        holdReset();
        checkQuiet(latency);

        testName = "knownAnswer";
        for (int i = 0; i < vectorCount; i++) begin
            issueVector(i);
            idleCycle();
            waitDrain();
        end

        testName = "backToBack";
        issuedStart = issuedCount;
        receivedStart = receivedCount;
        for (int i = 0; i < vectorCount; i++) begin
            issueVector(i);
        end
        idleCycle();
        waitDrain();
        checkValue("backToBack count", giftStateT'(issuedCount - issuedStart),
                   giftStateT'(receivedCount - receivedStart));

        testName = "randomGaps";
        issuedStart = issuedCount;
        receivedStart = receivedCount;
        for (int pass = 0; pass < 3; pass++) begin
            for (int i = 0; i < vectorCount; i++) begin
                drawGap(gap);
                repeat (gap) idleCycle();
                issueVector(i);
            end
        end
        idleCycle();
        waitDrain();
        checkValue("randomGaps count", giftStateT'(issuedCount - issuedStart),
                   giftStateT'(receivedCount - receivedStart));

        testName = "resetMidFlight";
        for (int i = 0; i < vectorCount; i++) begin
            issueVector(i);
        end
        @(posedge inClk);
        reset   <= 1'b1;
        inValid <= 1'b0;
        expQueue.delete();
        stampQueue.delete();
        holdReset();
        checkQuiet(latency);
        issueVector(vectorCount - 1);
        idleCycle();
        waitDrain();

        closeRun();
    end

endmodule

/* list.f */
+incdir+source
source/giftStatePkg.sv
source/giftConstPkg.sv
source/giftInvRound.sv
source/giftKeyPipe.sv
source/giftDataPipe.sv
source/giftDecryptTop.sv
dv/giftDecryptTb.sv

/* run.sh */
#!/bin/sh
# Builds the GIFT-128 decryptor testbench with Verilator, runs it and
# checks the log for the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module giftDecryptTb \
    -Mdir obj_dir -o simGift
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simGift > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

grep -qx "Test OK" sim.log
if [ $? -ne 0 ]; then
    echo "Pass line not found in sim.log"
    exit 1
fi

echo "Simulation passed"
exit 0

/* dv/gift_testdata.hex */
// Columns: final round-key state, ciphertext, expected plaintext (128-bit hex each)
// Final round-key state is the user key after 39 key-schedule updates
00000000000000000000000000000000 cd0bd738388ad3f668b15a36ceb6ff92 00000000000000000000000000000000
47651032cfed98ba476510323fb7a98b 8422241a6dbf5a9346af468409ee0152 fedcba9876543210fedcba9876543210
0770e7d32990a98faf9037d8743d59ac 13ede67cbdcc3dbf400a62d6977265ea e39c141fa57dba43f08a85b6a91f86c1
